//--- atop_pkg.sv
package atop_pkg;

  // Bus geometry
  localparam int unsigned ID_WIDTH   = 4;
  localparam int unsigned ADDR_WIDTH = 16;
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned LEN_WIDTH  = 8;

  // Downstream AWs allowed to wait for their W bursts
  localparam int unsigned MAX_WRITE_TXNS = 4;
  // Counts 0..MAX_WRITE_TXNS, all ones doubles as minus one
  localparam int unsigned CNT_WIDTH      = 3;

  // Response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // Atop bit asking for an R response
  localparam int unsigned ATOP_R_RESP = 5;

  typedef logic [ID_WIDTH-1:0]     id_t;
  typedef logic [ADDR_WIDTH-1:0]   addr_t;
  typedef logic [DATA_WIDTH-1:0]   data_t;
  typedef logic [DATA_WIDTH/8-1:0] strb_t;
  typedef logic [LEN_WIDTH-1:0]    len_t;
  typedef logic [5:0]              atop_t;
  typedef logic [1:0]              resp_t;
  typedef logic [CNT_WIDTH-1:0]    cnt_t;

  // Write address, trimmed to the fields the filter cares about
  typedef struct packed {
    id_t   id;
    addr_t addr;
    len_t  len;
    atop_t atop;
  } aw_chan_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } w_chan_t;

  typedef struct packed {
    id_t   id;
    resp_t resp;
  } b_chan_t;

  typedef struct packed {
    id_t   id;
    addr_t addr;
    len_t  len;
  } ar_chan_t;

  typedef struct packed {
    id_t   id;
    data_t data;
    resp_t resp;
    logic  last;
  } r_chan_t;

  // Write side controller states
  typedef enum logic [2:0] {
    W_FEEDTHROUGH, BLOCK_AW, ABSORB_W, HOLD_B, INJECT_B, WAIT_R
  } w_state_e;

  // Read side injector states
  typedef enum logic [1:0] {
    R_FEEDTHROUGH, INJECT_R, R_HOLD
  } r_state_e;

endpackage

//--- atop_w_tracker.sv
`timescale 1ns/1ns

module atop_w_tracker (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic aw_fire_i,
  input  logic w_last_fire_i,
  output logic aw_room_o,
  output logic w_missing_o,
  output logic w_ahead_o
);

  atop_pkg::cnt_t cnt_d, cnt_q;
  logic           uflow_d, uflow_q;

  // Up on downstream AW, down on downstream W last
  always_comb begin
    cnt_d   = cnt_q;
    uflow_d = uflow_q;
    if (aw_fire_i) begin
      cnt_d = cnt_d + atop_pkg::cnt_t'(1);
    end
    if (w_last_fire_i) begin
      cnt_d = cnt_d - atop_pkg::cnt_t'(1);
    end
    // Minus one entered from zero, left when back at zero
    if (uflow_q && (cnt_d == '0)) begin
      uflow_d = 1'b0;
    end else if ((cnt_q == '0) && (&cnt_d)) begin
      uflow_d = 1'b1;
    end
  end

  // AWs downstream still waiting for W
  assign w_missing_o = !uflow_q && (cnt_q != '0);
  // One complete W burst downstream with no AW yet
  assign w_ahead_o   = uflow_q && (&cnt_q);
  // A pending AW always fits if it pairs with a W burst already sent
  assign aw_room_o   = w_ahead_o ||
                       (cnt_q < atop_pkg::cnt_t'(atop_pkg::MAX_WRITE_TXNS));

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q   <= '0;
      uflow_q <= 1'b0;
    end else begin
      cnt_q   <= cnt_d;
      uflow_q <= uflow_d;
    end
  end

endmodule

//--- atop_write_ctrl.sv
`timescale 1ns/1ns

module atop_write_ctrl (
  input  logic               clk_i,
  input  logic               rst_ni,
  // Slave side
  input  atop_pkg::aw_chan_t slv_aw_i,
  input  logic               slv_aw_valid_i,
  output logic               slv_aw_ready_o,
  input  atop_pkg::w_chan_t  slv_w_i,
  input  logic               slv_w_valid_i,
  output logic               slv_w_ready_o,
  output atop_pkg::b_chan_t  slv_b_o,
  output logic               slv_b_valid_o,
  input  logic               slv_b_ready_i,
  // Master side
  output atop_pkg::aw_chan_t mst_aw_o,
  output logic               mst_aw_valid_o,
  input  logic               mst_aw_ready_i,
  output atop_pkg::w_chan_t  mst_w_o,
  output logic               mst_w_valid_o,
  input  logic               mst_w_ready_i,
  input  atop_pkg::b_chan_t  mst_b_i,
  input  logic               mst_b_valid_i,
  output logic               mst_b_ready_o,
  // Tracker status
  input  logic               aw_room_i,
  input  logic               w_missing_i,
  input  logic               w_ahead_i,
  // Read injector
  input  logic               r_busy_i,
  output logic               r_cmd_push_o,
  output atop_pkg::len_t     r_cmd_len_o,
  output atop_pkg::id_t      r_cmd_id_o
);

  atop_pkg::w_state_e state_d, state_q;
  atop_pkg::w_state_e after_w;
  atop_pkg::id_t      id_q;
  logic               aw_is_atop;
  logic               aw_absorb;
  logic               w_last_in;

  assign aw_is_atop = slv_aw_valid_i && (slv_aw_i.atop[5:4] != 2'b00);
  assign w_last_in  = slv_w_valid_i && slv_w_i.last;

  // A stalled forwarded B must finish before ours goes out
  assign after_w = (mst_b_valid_i && !slv_b_ready_i) ? atop_pkg::HOLD_B : atop_pkg::INJECT_B;

  // Payload goes straight through, atop never reaches the slave
  always_comb begin
    mst_aw_o      = slv_aw_i;
    mst_aw_o.atop = '0;
  end
  assign mst_w_o = slv_w_i;

  // R command carries the burst shape of the atomic AW
  assign r_cmd_len_o = slv_aw_i.len;
  assign r_cmd_id_o  = slv_aw_i.id;

  always_comb begin
    // Handshakes closed unless the state opens them
    mst_aw_valid_o = 1'b0;
    slv_aw_ready_o = 1'b0;
    mst_w_valid_o  = 1'b0;
    slv_w_ready_o  = 1'b0;
    // B forwarded by default
    slv_b_o        = mst_b_i;
    slv_b_valid_o  = mst_b_valid_i;
    mst_b_ready_o  = slv_b_ready_i;
    r_cmd_push_o   = 1'b0;
    aw_absorb      = 1'b0;
    state_d        = state_q;

    unique case (state_q)
      atop_pkg::W_FEEDTHROUGH: begin
        // AW out only while the in-flight limit allows
        if (aw_room_i) begin
          mst_aw_valid_o = slv_aw_valid_i;
          slv_aw_ready_o = mst_aw_ready_i;
        end
        // W out if its AW is downstream, or a plain AW is going with it
        // and no W burst is already ahead
        if (w_missing_i ||
            (slv_aw_valid_i && !aw_is_atop && !w_ahead_i)) begin
          mst_w_valid_o = slv_w_valid_i;
          slv_w_ready_o = mst_w_ready_i;
        end
        if (aw_is_atop) begin
          // Take the atomic AW here, it never goes downstream
          mst_aw_valid_o = 1'b0;
          slv_aw_ready_o = 1'b1;
          aw_absorb      = 1'b1;
          r_cmd_push_o   = slv_aw_i.atop[atop_pkg::ATOP_R_RESP];
          if (w_missing_i) begin
            // Earlier W bursts still owed downstream
            state_d = atop_pkg::BLOCK_AW;
          end else begin
            mst_w_valid_o = 1'b0;
            slv_w_ready_o = 1'b1;
            state_d       = w_last_in ? after_w : atop_pkg::ABSORB_W;
          end
        end
      end

      atop_pkg::BLOCK_AW: begin
        if (w_missing_i) begin
          // Drain W of the AWs already sent
          mst_w_valid_o = slv_w_valid_i;
          slv_w_ready_o = mst_w_ready_i;
        end else begin
          // Next W burst belongs to the atomic AW
          slv_w_ready_o = 1'b1;
          state_d       = w_last_in ? after_w : atop_pkg::ABSORB_W;
        end
      end

      atop_pkg::ABSORB_W: begin
        slv_w_ready_o = 1'b1;
        if (w_last_in) begin
          state_d = after_w;
        end
      end

      atop_pkg::HOLD_B: begin
        if (mst_b_valid_i && slv_b_ready_i) begin
          state_d = atop_pkg::INJECT_B;
        end
      end

      atop_pkg::INJECT_B: begin
        // Forwarding paused while the error B is out
        mst_b_ready_o = 1'b0;
        slv_b_o.id    = id_q;
        slv_b_o.resp  = atop_pkg::RESP_SLVERR;
        slv_b_valid_o = 1'b1;
        if (slv_b_ready_i) begin
          state_d = r_busy_i ? atop_pkg::WAIT_R : atop_pkg::W_FEEDTHROUGH;
        end
      end

      atop_pkg::WAIT_R: begin
        // Command slot must be free before the next atomic AW
        if (!r_busy_i) begin
          state_d = atop_pkg::W_FEEDTHROUGH;
        end
      end

      default: state_d = atop_pkg::W_FEEDTHROUGH;
    endcase
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= atop_pkg::W_FEEDTHROUGH;
    end else begin
      state_q <= state_d;
    end
  end

  // ID of the absorbed AW, replayed on B
  always_ff @(posedge clk_i) begin
    if (aw_absorb) begin
      id_q <= slv_aw_i.id;
    end
  end

endmodule

//--- atop_r_inject.sv
`timescale 1ns/1ns

module atop_r_inject (
  input  logic              clk_i,
  input  logic              rst_ni,
  // Command from the write controller
  input  logic              r_cmd_push_i,
  input  atop_pkg::len_t    r_cmd_len_i,
  input  atop_pkg::id_t     r_cmd_id_i,
  // Slave side R
  output atop_pkg::r_chan_t slv_r_o,
  output logic              slv_r_valid_o,
  input  logic              slv_r_ready_i,
  // Master side R
  input  atop_pkg::r_chan_t mst_r_i,
  input  logic              mst_r_valid_i,
  output logic              mst_r_ready_o,
  output logic              r_busy_o
);

  atop_pkg::r_state_e state_d, state_q;
  atop_pkg::len_t     beats_d, beats_q;
  atop_pkg::len_t     cmd_len_q;
  atop_pkg::len_t     start_len;
  atop_pkg::id_t      cmd_id_q;
  logic               cmd_valid_d, cmd_valid_q;
  logic               cmd_pending;

  // Fresh push starts at once, no wait for the register
  assign cmd_pending = r_cmd_push_i || cmd_valid_q;
  assign start_len   = r_cmd_push_i ? r_cmd_len_i : cmd_len_q;

  assign r_busy_o = cmd_valid_q;

  always_comb begin
    // R forwarded by default
    slv_r_o       = mst_r_i;
    slv_r_valid_o = mst_r_valid_i;
    mst_r_ready_o = slv_r_ready_i;
    beats_d       = beats_q;
    cmd_valid_d   = cmd_valid_q || r_cmd_push_i;
    state_d       = state_q;

    unique case (state_q)
      atop_pkg::R_FEEDTHROUGH: begin
        if (mst_r_valid_i && !slv_r_ready_i) begin
          // Beat stalled, it has to go first
          state_d = atop_pkg::R_HOLD;
        end else if (cmd_pending) begin
          beats_d = start_len;
          state_d = atop_pkg::INJECT_R;
        end
      end

      atop_pkg::INJECT_R: begin
        // Hold downstream R back during injection
        mst_r_ready_o = 1'b0;
        slv_r_o       = '0;
        slv_r_o.id    = cmd_id_q;
        slv_r_o.resp  = atop_pkg::RESP_SLVERR;
        slv_r_o.last  = (beats_q == '0);
        slv_r_valid_o = 1'b1;
        if (slv_r_ready_i) begin
          if (beats_q == '0) begin
            // Burst done, free the command slot
            cmd_valid_d = 1'b0;
            state_d     = atop_pkg::R_FEEDTHROUGH;
          end else begin
            beats_d = beats_q - atop_pkg::len_t'(1);
          end
        end
      end

      atop_pkg::R_HOLD: begin
        if (mst_r_valid_i && slv_r_ready_i) begin
          if (cmd_pending) begin
            beats_d = start_len;
            state_d = atop_pkg::INJECT_R;
          end else begin
            state_d = atop_pkg::R_FEEDTHROUGH;
          end
        end
      end

      default: state_d = atop_pkg::R_FEEDTHROUGH;
    endcase
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= atop_pkg::R_FEEDTHROUGH;
      beats_q     <= '0;
      cmd_valid_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      beats_q     <= beats_d;
      cmd_valid_q <= cmd_valid_d;
    end
  end

  // One entry command store
  always_ff @(posedge clk_i) begin
    if (r_cmd_push_i) begin
      cmd_len_q <= r_cmd_len_i;
      cmd_id_q  <= r_cmd_id_i;
    end
  end

endmodule

//--- atop_filter.sv
`timescale 1ns/1ns

module atop_filter (
  input  logic               clk_i,
  input  logic               rst_ni,
  // Slave side, facing the master that issues atomics
  input  atop_pkg::aw_chan_t slv_aw_i,
  input  logic               slv_aw_valid_i,
  output logic               slv_aw_ready_o,
  input  atop_pkg::w_chan_t  slv_w_i,
  input  logic               slv_w_valid_i,
  output logic               slv_w_ready_o,
  output atop_pkg::b_chan_t  slv_b_o,
  output logic               slv_b_valid_o,
  input  logic               slv_b_ready_i,
  input  atop_pkg::ar_chan_t slv_ar_i,
  input  logic               slv_ar_valid_i,
  output logic               slv_ar_ready_o,
  output atop_pkg::r_chan_t  slv_r_o,
  output logic               slv_r_valid_o,
  input  logic               slv_r_ready_i,
  // Master side, facing the slave without atomic support
  output atop_pkg::aw_chan_t mst_aw_o,
  output logic               mst_aw_valid_o,
  input  logic               mst_aw_ready_i,
  output atop_pkg::w_chan_t  mst_w_o,
  output logic               mst_w_valid_o,
  input  logic               mst_w_ready_i,
  input  atop_pkg::b_chan_t  mst_b_i,
  input  logic               mst_b_valid_i,
  output logic               mst_b_ready_o,
  output atop_pkg::ar_chan_t mst_ar_o,
  output logic               mst_ar_valid_o,
  input  logic               mst_ar_ready_i,
  input  atop_pkg::r_chan_t  mst_r_i,
  input  logic               mst_r_valid_i,
  output logic               mst_r_ready_o
);

  logic           aw_fire, w_last_fire;
  logic           aw_room, w_missing, w_ahead;
  logic           r_busy, r_cmd_push;
  atop_pkg::len_t r_cmd_len;
  atop_pkg::id_t  r_cmd_id;

  // Downstream handshakes seen by the tracker
  assign aw_fire     = mst_aw_valid_o && mst_aw_ready_i;
  assign w_last_fire = mst_w_valid_o && mst_w_ready_i && mst_w_o.last;

  atop_w_tracker i_w_tracker (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .aw_fire_i     (aw_fire),
    .w_last_fire_i (w_last_fire),
    .aw_room_o     (aw_room),
    .w_missing_o   (w_missing),
    .w_ahead_o     (w_ahead)
  );

  atop_write_ctrl i_write_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .slv_aw_i       (slv_aw_i),
    .slv_aw_valid_i (slv_aw_valid_i),
    .slv_aw_ready_o (slv_aw_ready_o),
    .slv_w_i        (slv_w_i),
    .slv_w_valid_i  (slv_w_valid_i),
    .slv_w_ready_o  (slv_w_ready_o),
    .slv_b_o        (slv_b_o),
    .slv_b_valid_o  (slv_b_valid_o),
    .slv_b_ready_i  (slv_b_ready_i),
    .mst_aw_o       (mst_aw_o),
    .mst_aw_valid_o (mst_aw_valid_o),
    .mst_aw_ready_i (mst_aw_ready_i),
    .mst_w_o        (mst_w_o),
    .mst_w_valid_o  (mst_w_valid_o),
    .mst_w_ready_i  (mst_w_ready_i),
    .mst_b_i        (mst_b_i),
    .mst_b_valid_i  (mst_b_valid_i),
    .mst_b_ready_o  (mst_b_ready_o),
    .aw_room_i      (aw_room),
    .w_missing_i    (w_missing),
    .w_ahead_i      (w_ahead),
    .r_busy_i       (r_busy),
    .r_cmd_push_o   (r_cmd_push),
    .r_cmd_len_o    (r_cmd_len),
    .r_cmd_id_o     (r_cmd_id)
  );

  atop_r_inject i_r_inject (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .r_cmd_push_i  (r_cmd_push),
    .r_cmd_len_i   (r_cmd_len),
    .r_cmd_id_i    (r_cmd_id),
    .slv_r_o       (slv_r_o),
    .slv_r_valid_o (slv_r_valid_o),
    .slv_r_ready_i (slv_r_ready_i),
    .mst_r_i       (mst_r_i),
    .mst_r_valid_i (mst_r_valid_i),
    .mst_r_ready_o (mst_r_ready_o),
    .r_busy_o      (r_busy)
  );

  // Reads need no filtering
  assign mst_ar_o       = slv_ar_i;
  assign mst_ar_valid_o = slv_ar_valid_i;
  assign slv_ar_ready_o = mst_ar_ready_i;

endmodule

//--- tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  // 40 ns period
  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;
  end

  // Reset held low for the first 2 rising edges
  initial begin
    rst_no = 1'b0;
    repeat (2) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

//--- tb_atop_filter.sv
`timescale 1ns/1ns

module tb_atop_filter;

  localparam int TMO = 400;

  logic clk_i;
  logic rst_ni;

  // Slave side, driven by the test process
  atop_pkg::aw_chan_t slv_aw_i       = '0;
  logic               slv_aw_valid_i = 1'b0;
  logic               slv_aw_ready_o;
  atop_pkg::w_chan_t  slv_w_i        = '0;
  logic               slv_w_valid_i  = 1'b0;
  logic               slv_w_ready_o;
  atop_pkg::b_chan_t  slv_b_o;
  logic               slv_b_valid_o;
  logic               slv_b_ready_i  = 1'b1;
  atop_pkg::ar_chan_t slv_ar_i       = '0;
  logic               slv_ar_valid_i = 1'b0;
  logic               slv_ar_ready_o;
  atop_pkg::r_chan_t  slv_r_o;
  logic               slv_r_valid_o;
  logic               slv_r_ready_i  = 1'b1;
  // Master side, driven by the downstream model
  atop_pkg::aw_chan_t mst_aw_o;
  logic               mst_aw_valid_o;
  logic               mst_aw_ready_i = 1'b0;
  atop_pkg::w_chan_t  mst_w_o;
  logic               mst_w_valid_o;
  logic               mst_w_ready_i  = 1'b0;
  atop_pkg::b_chan_t  mst_b_i        = '0;
  logic               mst_b_valid_i  = 1'b0;
  logic               mst_b_ready_o;
  atop_pkg::ar_chan_t mst_ar_o;
  logic               mst_ar_valid_o;
  logic               mst_ar_ready_i = 1'b0;
  atop_pkg::r_chan_t  mst_r_i        = '0;
  logic               mst_r_valid_i  = 1'b0;
  logic               mst_r_ready_o;

  // Expected traffic, filled by the stimulus tasks
  atop_pkg::aw_chan_t exp_aw[$];
  atop_pkg::w_chan_t  exp_w[$];
  atop_pkg::b_chan_t  exp_b[$];
  atop_pkg::ar_chan_t exp_ar[$];
  atop_pkg::r_chan_t  exp_r[$];

  // Downstream model state
  atop_pkg::id_t      aw_ids[$];
  atop_pkg::id_t      b_q[$];
  atop_pkg::ar_chan_t ar_q[$];
  int                 wlast_cnt = 0;
  int                 out_cnt   = 0;
  int                 r_idx     = 0;
  logic               w_block   = 1'b0;
  logic               rand_resp = 1'b0;
  logic [31:0]        rng       = 32'hcff79dbc;

  int    errors   = 0;
  int    n_tests  = 0;
  int    n_failed = 0;
  string cur_test = "reset";

  tb_clk_gen i_clk_gen (
    .clk_o  (clk_i),
    .rst_no (rst_ni)
  );

  atop_filter i_atop_filter (.*);

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic note_mismatch(input string chan, input logic [63:0] exp, input logic [63:0] act);
    errors++;
    $display("Error %s: %s expected %h actual %h", cur_test, chan, exp, act);
  endtask

  task automatic note_error(input string what);
    errors++;
    $display("%s: %s", cur_test, what);
  endtask

  task automatic timeout_fail(input string what);
    $display("%s: gave up waiting for %s", cur_test, what);
    $display("=== FAIL ===");
    $finish;
  endtask

  // Oldest expected B of this ID, responses of one ID stay in order
  function automatic int first_b_for_id(input atop_pkg::id_t id);
    foreach (exp_b[i]) begin
      if (exp_b[i].id == id) return i;
    end
    return -1;
  endfunction

  // Oldest expected R beat of this ID
  function automatic int first_r_for_id(input atop_pkg::id_t id);
    foreach (exp_r[i]) begin
      if (exp_r[i].id == id) return i;
    end
    return -1;
  endfunction

  function automatic int outstanding_count();
    return exp_aw.size() + exp_w.size() + exp_b.size() + exp_ar.size() + exp_r.size();
  endfunction

  // Downstream slave with random ready, answers in order
  always @(posedge clk_i) begin
    rng = xorshift(rng);
    if (!rst_ni) begin
      mst_b_valid_i <= 1'b0;
      mst_r_valid_i <= 1'b0;
    end else begin
      mst_aw_ready_i <= rng[0];
      mst_w_ready_i  <= !w_block && rng[1];
      mst_ar_ready_i <= rng[2];
      slv_b_ready_i  <= !rand_resp || rng[3];
      slv_r_ready_i  <= !rand_resp || rng[4];
      if (mst_aw_valid_o && mst_aw_ready_i) begin
        if (exp_aw.size() == 0) begin
          note_error("unexpected AW handshake on the master side");
        end else begin
          assert (mst_aw_o == exp_aw[0])
            else note_mismatch("master AW", 64'(exp_aw[0]), 64'(mst_aw_o));
          void'(exp_aw.pop_front());
        end
        aw_ids.push_back(mst_aw_o.id);
        out_cnt++;
      end
      if (mst_w_valid_o && mst_w_ready_i) begin
        if (exp_w.size() == 0) begin
          note_error("unexpected W beat on the master side");
        end else begin
          assert (mst_w_o == exp_w[0])
            else note_mismatch("master W", 64'(exp_w[0]), 64'(mst_w_o));
          void'(exp_w.pop_front());
        end
        if (mst_w_o.last) begin
          wlast_cnt++;
          out_cnt--;
        end
      end
      assert (out_cnt <= int'(atop_pkg::MAX_WRITE_TXNS))
        else note_error("too many AW bursts downstream without their W bursts");
      // AW and W last together make one B
      if (aw_ids.size() > 0 && wlast_cnt > 0) begin
        b_q.push_back(aw_ids.pop_front());
        wlast_cnt--;
      end
      if (!mst_b_valid_i || mst_b_ready_o) begin
        if (b_q.size() > 0) begin
          mst_b_i.id    <= b_q.pop_front();
          mst_b_i.resp  <= atop_pkg::RESP_OKAY;
          mst_b_valid_i <= 1'b1;
        end else begin
          mst_b_valid_i <= 1'b0;
        end
      end
      if (mst_ar_valid_o && mst_ar_ready_i) begin
        if (exp_ar.size() == 0) begin
          note_error("unexpected AR handshake on the master side");
        end else begin
          assert (mst_ar_o == exp_ar[0])
            else note_mismatch("master AR", 64'(exp_ar[0]), 64'(mst_ar_o));
          void'(exp_ar.pop_front());
        end
        ar_q.push_back(mst_ar_o);
      end
      // R data is the address plus the beat index
      if (!mst_r_valid_i || mst_r_ready_o) begin
        if (ar_q.size() > 0) begin
          mst_r_i.id    <= ar_q[0].id;
          mst_r_i.data  <= atop_pkg::data_t'(ar_q[0].addr) + atop_pkg::data_t'(r_idx);
          mst_r_i.resp  <= atop_pkg::RESP_OKAY;
          mst_r_i.last  <= (atop_pkg::len_t'(r_idx) == ar_q[0].len);
          mst_r_valid_i <= 1'b1;
          if (atop_pkg::len_t'(r_idx) == ar_q[0].len) begin
            void'(ar_q.pop_front());
            r_idx = 0;
          end else begin
            r_idx++;
          end
        end else begin
          mst_r_valid_i <= 1'b0;
        end
      end
    end
  end

  // Every slave side response must be the next one expected for its ID
  always @(posedge clk_i) begin : slave_monitor
    int idx;
    if (rst_ni) begin
      if (slv_b_valid_o && slv_b_ready_i) begin
        idx = first_b_for_id(slv_b_o.id);
        if (idx < 0) begin
          note_error("B response arrived with an ID that has none expected");
        end else begin
          assert (slv_b_o == exp_b[idx])
            else note_mismatch("slave B", 64'(exp_b[idx]), 64'(slv_b_o));
          exp_b.delete(idx);
        end
      end
      if (slv_r_valid_o && slv_r_ready_i) begin
        idx = first_r_for_id(slv_r_o.id);
        if (idx < 0) begin
          note_error("R beat arrived with an ID that has none expected");
        end else begin
          assert (slv_r_o == exp_r[idx])
            else note_mismatch("slave R", 64'(exp_r[idx]), 64'(slv_r_o));
          exp_r.delete(idx);
        end
      end
    end
  end

  task automatic drive_aw(input atop_pkg::aw_chan_t aw);
    int t;
    @(posedge clk_i);
    slv_aw_i       <= aw;
    slv_aw_valid_i <= 1'b1;
    t = 0;
    do begin
      @(posedge clk_i);
      t++;
    end while (!slv_aw_ready_o && t < TMO);
    if (!slv_aw_ready_o) timeout_fail("slave AW ready");
    slv_aw_valid_i <= 1'b0;
  endtask

  task automatic drive_w(input int len, input atop_pkg::data_t base);
    int t;
    for (int i = 0; i <= len; i++) begin
      @(posedge clk_i);
      slv_w_i.data  <= base + atop_pkg::data_t'(i);
      slv_w_i.strb  <= '1;
      slv_w_i.last  <= (i == len);
      slv_w_valid_i <= 1'b1;
      t = 0;
      do begin
        @(posedge clk_i);
        t++;
      end while (!slv_w_ready_o && t < TMO);
      if (!slv_w_ready_o) timeout_fail("slave W ready");
      slv_w_valid_i <= 1'b0;
    end
  endtask

  task automatic drive_ar(input atop_pkg::ar_chan_t ar);
    int t;
    @(posedge clk_i);
    slv_ar_i       <= ar;
    slv_ar_valid_i <= 1'b1;
    t = 0;
    do begin
      @(posedge clk_i);
      t++;
    end while (!slv_ar_ready_o && t < TMO);
    if (!slv_ar_ready_o) timeout_fail("slave AR ready");
    slv_ar_valid_i <= 1'b0;
  endtask

  function automatic atop_pkg::aw_chan_t make_aw(input int id, input int addr, input int len,
                                                 input atop_pkg::atop_t atop);
    atop_pkg::aw_chan_t aw;
    aw.id   = atop_pkg::id_t'(id);
    aw.addr = atop_pkg::addr_t'(addr);
    aw.len  = atop_pkg::len_t'(len);
    aw.atop = atop;
    return aw;
  endfunction

  // Master AW keeps id, addr and len with atop cleared
  task automatic expect_plain(input int id, input int addr, input int len,
                              input atop_pkg::data_t base);
    atop_pkg::b_chan_t b;
    atop_pkg::w_chan_t w;
    exp_aw.push_back(make_aw(id, addr, len, '0));
    for (int i = 0; i <= len; i++) begin
      w.data = base + atop_pkg::data_t'(i);
      w.strb = '1;
      w.last = (i == len);
      exp_w.push_back(w);
    end
    b.id   = atop_pkg::id_t'(id);
    b.resp = atop_pkg::RESP_OKAY;
    exp_b.push_back(b);
  endtask

  task automatic plain_write(input int id, input int addr, input int len,
                             input atop_pkg::data_t base);
    expect_plain(id, addr, len, base);
    fork
      drive_aw(make_aw(id, addr, len, 6'b000000));
      drive_w(len, base);
    join
  endtask

  // Atomic write answered with SLVERR, plus R beats if bit 5 is set
  task automatic atomic_write(input int id, input int addr, input int len,
                              input atop_pkg::atop_t atop);
    atop_pkg::b_chan_t b;
    atop_pkg::r_chan_t r;
    b.id   = atop_pkg::id_t'(id);
    b.resp = atop_pkg::RESP_SLVERR;
    exp_b.push_back(b);
    if (atop[5]) begin
      for (int i = 0; i <= len; i++) begin
        r.id   = atop_pkg::id_t'(id);
        r.data = '0;
        r.resp = atop_pkg::RESP_SLVERR;
        r.last = (i == len);
        exp_r.push_back(r);
      end
    end
    fork
      drive_aw(make_aw(id, addr, len, atop));
      drive_w(len, 32'hdead_0000);
    join
  endtask

  task automatic read(input int id, input int addr, input int len);
    atop_pkg::ar_chan_t ar;
    atop_pkg::r_chan_t  r;
    ar.id   = atop_pkg::id_t'(id);
    ar.addr = atop_pkg::addr_t'(addr);
    ar.len  = atop_pkg::len_t'(len);
    exp_ar.push_back(ar);
    for (int i = 0; i <= len; i++) begin
      r.id   = ar.id;
      r.data = atop_pkg::data_t'(ar.addr) + atop_pkg::data_t'(i);
      r.resp = atop_pkg::RESP_OKAY;
      r.last = (i == len);
      exp_r.push_back(r);
    end
    drive_ar(ar);
  endtask

  // Test ends once every expected transfer has been seen
  task automatic finish_test(input int err_start);
    int t;
    t = 0;
    while (outstanding_count() > 0 && t < TMO) begin
      @(posedge clk_i);
      t++;
    end
    if (outstanding_count() > 0) timeout_fail("outstanding responses");
    n_tests++;
    if (errors != err_start) n_failed++;
    $display("%s: %s (%0d errors)", cur_test, (errors == err_start) ? "ok" : "failed",
             errors - err_start);
  endtask

  initial begin
    int t;
    int e;
    t = 0;
    while (!rst_ni && t < TMO) begin
      @(posedge clk_i);
      t++;
    end
    if (!rst_ni) timeout_fail("reset release");

    cur_test = "plain_write";
    e = errors;
    plain_write(1, 16'h0100, 3, 32'h1000_0000);
    plain_write(2, 16'h0200, 0, 32'h2000_0000);
    finish_test(e);

    cur_test = "atomic_store";
    e = errors;
    atomic_write(3, 16'h0300, 3, 6'b010000);
    finish_test(e);

    cur_test = "atomic_with_r";
    e = errors;
    atomic_write(4, 16'h0400, 2, 6'b100001);
    finish_test(e);

    cur_test = "read_feedthrough";
    e = errors;
    read(5, 16'h0500, 3);
    finish_test(e);

    // AWs pile up downstream while W is stalled
    cur_test = "write_limit";
    e = errors;
    w_block <= 1'b1;
    for (int i = 0; i < 6; i++) expect_plain(i, 16'h0600 + i * 16, 1, 32'h6000_0000 + i * 256);
    fork
      for (int i = 0; i < 6; i++) drive_aw(make_aw(i, 16'h0600 + i * 16, 1, '0));
      for (int i = 0; i < 6; i++) drive_w(1, 32'h6000_0000 + i * 256);
      begin
        t = 0;
        while (out_cnt < int'(atop_pkg::MAX_WRITE_TXNS) && t < TMO) begin
          @(posedge clk_i);
          t++;
        end
        if (out_cnt < int'(atop_pkg::MAX_WRITE_TXNS)) timeout_fail("the AW limit to be reached");
        // W stays stalled at the limit while more AWs wait with ready toggling
        repeat (20) @(posedge clk_i);
        w_block <= 1'b0;
      end
    join
    finish_test(e);

    cur_test = "backpressure_mix";
    e = errors;
    rand_resp <= 1'b1;
    fork
      for (int i = 0; i < 6; i++) begin
        case (i % 3)
          0: plain_write(8 + i, 16'h0800 + i * 16, i % 4, 32'h8000_0000 + i * 256);
          1: atomic_write(8 + i, 16'h0800 + i * 16, 1, 6'b010010);
          default: atomic_write(8 + i, 16'h0800 + i * 16, 2, 6'b100100);
        endcase
      end
      for (int i = 0; i < 4; i++) read(i, 16'h0900 + i * 32, i + 1);
    join
    finish_test(e);
    rand_resp <= 1'b0;

    // Quiet period catches late extra responses
    repeat (20) @(posedge clk_i);

    $display("tests %0d, failed %0d, errors %0d", n_tests, n_failed, errors);
    if (errors == 0 && n_failed == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- list.f
atop_pkg.sv
atop_w_tracker.sv
atop_write_ctrl.sv
atop_r_inject.sv
atop_filter.sv
tb_clk_gen.sv
tb_atop_filter.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing
TOP       := tb_atop_filter
FILELIST  := list.f
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
